/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

check:
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
source/exec_pkg.sv
source/alu.sv
source/multiplier.sv
source/divider.sv
source/branch_resolve.sv
source/exec_stage.sv
dv/exec_stage_sva.sv
dv/tb_exec_stage.sv

/* dv/exec_stage_sva.sv */
module exec_stage_sva #(
    parameter int XLEN = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_ready,
    input  logic                            out_valid,
    input  logic                            out_ready,
    input  logic [XLEN-1:0]                 out_pc,
    input  logic [XLEN-1:0]                 out_result,
    input  logic [XLEN-1:0]                 br_target,
    input  logic [exec_pkg::REG_ADDR_W-1:0] out_dest,
    input  logic                            out_gr_we,
    input  logic                            br_taken,
    input  exec_pkg::div_state_e            div_state
);

    // a stalled result keeps every field until taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_result)
            && $stable(out_dest) && $stable(out_gr_we) && $stable(br_taken)
            && $stable(br_target))
    else
        $error("output payload changed while the next stage stalled");

    // busy divider means the divide is still pending
    assert property (@(posedge clk) disable iff (reset)
        div_state != exec_pkg::DIV_IDLE |-> !in_ready)
    else
        $error("input side ready while the divider is busy");

    assert property (@(posedge clk) disable iff (reset) br_taken |-> out_valid)
    else
        $error("redirect flagged without a valid result");

    assert property (@(posedge clk) reset |=> !out_valid && !br_taken && in_ready
        && div_state == exec_pkg::DIV_IDLE)
    else
        $error("stage not idle after reset");

endmodule

bind exec_stage exec_stage_sva #(.XLEN(XLEN)) u_sva (
    .clk(clk), .reset(reset), .in_ready(in_ready), .out_valid(out_valid),
    .out_ready(out_ready), .out_pc(out_pc), .out_result(out_result), .br_target(br_target),
    .out_dest(out_dest), .out_gr_we(out_gr_we), .br_taken(br_taken),
    .div_state(u_div.state)
);

/* dv/tb_exec_stage.sv */
module tb_exec_stage;

    localparam int XLEN       = 32;
    localparam int N_INSTR    = 400;
    localparam int MAX_CYCLES = N_INSTR * 40 + 200; // as if every instruction were a divide

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] pc;
        logic [31:0] target;
        logic [4:0]  dest;
        logic        gr_we;
        logic        taken;
    } expected_t;

    logic                            clk;
    logic                            reset;
    logic                            in_valid;
    logic                            in_ready;
    exec_pkg::exec_op_e              in_op;
    logic [XLEN-1:0]                 in_pc, in_rj_value, in_rk_value, in_imm;
    logic [exec_pkg::REG_ADDR_W-1:0] in_rj_addr, in_rk_addr, in_dest, fwd_dest;
    logic                            in_src1_is_pc, in_src2_is_imm, in_gr_we;
    logic                            fwd_valid;
    logic [XLEN-1:0]                 fwd_data;
    logic                            out_valid, out_ready, out_gr_we, br_taken;
    logic [XLEN-1:0]                 out_pc, out_result, br_target;
    logic [exec_pkg::REG_ADDR_W-1:0] out_dest;

    expected_t   expected_q[$];
    logic [31:0] stim_state;
    logic [31:0] stall_state;
    int          cycle_count;
    int          checked_count;
    int          mismatch_count;
    int          other_errors;

    exec_stage #(.XLEN(XLEN)) UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_step(stim_state);
        return int'(r[31:8]) % n; // low lcg bits repeat quickly
    endfunction

    // random values with corner cases mixed in
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = lcg_step(stim_state);
        case (r[31:29])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h7fff_ffff;
            default: return lcg_step(stim_state);
        endcase
    endfunction

    function automatic exec_pkg::exec_op_e pick_op(input int idx);
        int code;
        if (idx < 80)
            code = rand_below(12);                        // alu and lui
        else if (idx < 140)
            code = 12 + rand_below(3);                    // multiply
        else if (idx < 220)
            code = (idx % 2 == 0) ? 15 + rand_below(4) : rand_below(12);
        else if (idx < 300)
            code = 19 + rand_below(9);                    // branches
        else
            code = rand_below(28);
        return exec_pkg::exec_op_e'(5'(code));
    endfunction

    function automatic logic [31:0] forwarded(input logic [31:0] value, input logic [4:0] addr);
        if (fwd_valid && fwd_dest != 5'd0 && fwd_dest == addr)
            return fwd_data;
        return value;
    endfunction

    function automatic expected_t expected_result(input exec_pkg::exec_op_e op,
        input logic [31:0] pc, input logic [31:0] rj, input logic [31:0] rk,
        input logic [31:0] imm, input logic s1_pc, input logic s2_imm,
        input logic [4:0] dest, input logic gr_we);
        expected_t          e;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        prod_u;
        logic               ovf;
        a = s1_pc ? pc : rj;
        b = s2_imm ? imm : rk;
        sa = $signed(a);
        sb = $signed(b);
        prod_u = {32'd0, a} * {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        e = '0;
        e.pc = pc;
        e.dest = dest;
        e.gr_we = gr_we;
        e.target = pc + imm;
        case (op)
            exec_pkg::OP_ADD:   e.result = a + b;
            exec_pkg::OP_SUB:   e.result = a - b;
            exec_pkg::OP_SLT:   e.result = 32'($signed(a) < $signed(b));
            exec_pkg::OP_SLTU:  e.result = 32'(a < b);
            exec_pkg::OP_AND:   e.result = a & b;
            exec_pkg::OP_OR:    e.result = a | b;
            exec_pkg::OP_XOR:   e.result = a ^ b;
            exec_pkg::OP_NOR:   e.result = ~(a | b);
            exec_pkg::OP_SLL:   e.result = a << b[4:0];
            exec_pkg::OP_SRL:   e.result = a >> b[4:0];
            exec_pkg::OP_SRA:   e.result = 32'($signed(a) >>> b[4:0]);
            exec_pkg::OP_LUI:   e.result = b << 12;
            exec_pkg::OP_MUL:   e.result = 32'(sa * sb);
            exec_pkg::OP_MULH:  e.result = 32'((sa * sb) >>> 32);
            exec_pkg::OP_MULHU: e.result = prod_u[63:32];
            exec_pkg::OP_DIV:   e.result = (b == 0) ? '1 : (ovf ? a : 32'(sa / sb));
            exec_pkg::OP_MOD:   e.result = (b == 0) ? a : (ovf ? 32'd0 : 32'(sa % sb));
            exec_pkg::OP_DIVU:  e.result = (b == 0) ? '1 : a / b;
            exec_pkg::OP_MODU:  e.result = (b == 0) ? a : a % b;
            exec_pkg::OP_BEQ:   e.taken = (rj == rk);
            exec_pkg::OP_BNE:   e.taken = (rj != rk);
            exec_pkg::OP_BLT:   e.taken = $signed(rj) < $signed(rk);
            exec_pkg::OP_BGE:   e.taken = $signed(rj) >= $signed(rk);
            exec_pkg::OP_BLTU:  e.taken = rj < rk;
            exec_pkg::OP_BGEU:  e.taken = rj >= rk;
            exec_pkg::OP_JIRL:
            begin
                e.taken = 1'b1;
                e.target = rj + imm; // register indirect
            end
            default:            e.taken = 1'b1; // b and bl
        endcase
        if (op >= exec_pkg::OP_BEQ)
        begin
            e.result = pc + 32'd4;
            e.gr_we = gr_we && (op == exec_pkg::OP_BL || op == exec_pkg::OP_JIRL);
        end
        return e;
    endfunction

    task automatic issue_instruction(input int idx);
        logic [31:0]        r;
        exec_pkg::exec_op_e op;
        op = pick_op(idx);
        if (rand_below(8) == 0)
        begin
            in_valid = 1'b0; // idle gap
            @(posedge clk);
            #1;
        end
        r = lcg_step(stim_state);
        in_op          = op;
        in_pc          = {r[31:2], 2'b00};
        in_rj_value    = pick_operand();
        in_rk_value    = pick_operand();
        in_imm         = pick_operand();
        r = lcg_step(stim_state);
        in_rj_addr     = {2'b00, r[31:29]}; // narrow range so the bypass hits often
        in_rk_addr     = {2'b00, r[28:26]};
        in_dest        = r[25:21];
        in_src1_is_pc  = r[20] & r[19];
        in_src2_is_imm = r[18] || op == exec_pkg::OP_LUI;
        in_gr_we       = r[17] | r[16];
        fwd_valid      = r[15];
        fwd_dest       = {2'b00, r[14:12]};
        fwd_data       = lcg_step(stim_state);
        if (idx >= 140 && idx < 220 && (idx % 16 == 0 || idx % 16 == 2))
        begin
            in_src1_is_pc  = 1'b0;
            in_src2_is_imm = 1'b0;
            fwd_valid      = 1'b0;
            in_rk_value    = 32'h0;
            if (idx % 16 == 0)
            begin
                // most negative over minus one
                in_op       = (idx % 32 == 0) ? exec_pkg::OP_DIV : exec_pkg::OP_MOD;
                in_rj_value = 32'h8000_0000;
                in_rk_value = 32'hffff_ffff;
            end
        end
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        expected_q.push_back(expected_result(in_op, in_pc, forwarded(in_rj_value, in_rj_addr),
            forwarded(in_rk_value, in_rk_addr), in_imm, in_src1_is_pc, in_src2_is_imm,
            in_dest, in_gr_we));
        @(posedge clk);
        #1;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
        input logic [31:0] want);
        assert (got == want)
        else
        begin
            mismatch_count++;
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge clk)
    begin : output_stalls
        logic [31:0] r;
        #1;
        r = lcg_step(stall_state);
        out_ready = r[31:30] != 2'b00; // roughly one stall in four
    end

    always @(posedge clk)
    begin : compare_outputs
        expected_t e;
        if (!reset && out_valid && out_ready)
        begin
            assert (expected_q.size() != 0)
            else
            begin
                other_errors++;
                $display("error at time %0t: result delivered with nothing outstanding", $time);
            end
            if (expected_q.size() != 0)
            begin
                e = expected_q.pop_front();
                checked_count++;
                compare_field("out_result", out_result, e.result);
                compare_field("out_pc", out_pc, e.pc);
                compare_field("out_dest", 32'(out_dest), 32'(e.dest));
                compare_field("out_gr_we", 32'(out_gr_we), 32'(e.gr_we));
                compare_field("br_taken", 32'(br_taken), 32'(e.taken));
                if (e.taken)
                    compare_field("br_target", br_target, e.target);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles with %0d results outstanding",
                cycle_count, expected_q.size());
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        stim_state     = 32'd51;
        stall_state    = 32'd51;
        cycle_count    = 0;
        checked_count  = 0;
        mismatch_count = 0;
        other_errors   = 0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = exec_pkg::OP_ADD;
        in_pc          = '0;
        in_rj_value    = '0;
        in_rk_value    = '0;
        in_imm         = '0;
        in_rj_addr     = '0;
        in_rk_addr     = '0;
        in_dest        = '0;
        in_src1_is_pc  = 1'b0;
        in_src2_is_imm = 1'b0;
        in_gr_we       = 1'b0;
        fwd_valid      = 1'b0;
        fwd_dest       = '0;
        fwd_data       = '0;
        out_ready      = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < N_INSTR; i++)
            issue_instruction(i);
        in_valid = 1'b0;
        while (expected_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk); // catch any stray extra result
        $display("checked %0d of %0d, mismatches %0d, other errors %0d",
            checked_count, N_INSTR, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0 && checked_count == N_INSTR)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* source/alu.sv */
module alu #(
    parameter int XLEN = 32
) (
    input  exec_pkg::exec_op_e op,
    input  logic [XLEN-1:0]    src1,
    input  logic [XLEN-1:0]    src2,
    output logic [XLEN-1:0]    result
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = src2[SHW-1:0]; // only low bits count
    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb
    begin
        case (op)
            exec_pkg::OP_ADD:  result = sum;
            exec_pkg::OP_SUB:  result = diff;
            exec_pkg::OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            exec_pkg::OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            exec_pkg::OP_AND:  result = src1 & src2;
            exec_pkg::OP_OR:   result = src1 | src2;
            exec_pkg::OP_XOR:  result = src1 ^ src2;
            exec_pkg::OP_NOR:  result = ~(src1 | src2);
            exec_pkg::OP_SLL:  result = src1 << shamt;
            exec_pkg::OP_SRL:  result = src1 >> shamt;
            exec_pkg::OP_SRA:
            begin
                result = $signed(src1) >>> shamt; // keeps the sign bit
            end
            exec_pkg::OP_LUI:  result = src2 << 12;
            default:           result = '0;
        endcase
    end

endmodule

/* source/branch_resolve.sv */
module branch_resolve #(
    parameter int XLEN = 32
) (
    input  exec_pkg::exec_op_e op,
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    rj,
    input  logic [XLEN-1:0]    rk,
    input  logic [XLEN-1:0]    imm,
    output logic               taken,
    output logic [XLEN-1:0]    target,
    output logic [XLEN-1:0]    link
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj == rk);
    assign lt_s = $signed(rj) < $signed(rk);
    assign lt_u = rj < rk;

    always_comb
    begin
        case (op)
            exec_pkg::OP_BEQ:  taken = eq;
            exec_pkg::OP_BNE:  taken = !eq;
            exec_pkg::OP_BLT:  taken = lt_s;
            exec_pkg::OP_BGE:  taken = !lt_s;
            exec_pkg::OP_BLTU: taken = lt_u;
            exec_pkg::OP_BGEU: taken = !lt_u;
            exec_pkg::OP_B, exec_pkg::OP_BL, exec_pkg::OP_JIRL: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign target = (op == exec_pkg::OP_JIRL) ? rj + imm : pc + imm; // indirect only for jirl
    assign link   = pc + XLEN'(4);

endmodule

/* source/divider.sv */
module divider #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            div_signed,
    input  logic            div_mod,
    input  logic [XLEN-1:0] x,
    input  logic [XLEN-1:0] y,
    output logic            done,
    output logic [XLEN-1:0] result
);

    localparam int CW = $clog2(XLEN);

    exec_pkg::div_state_e state;
    logic [CW-1:0]   count;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] divisor;
    logic [XLEN-1:0] dividend;
    logic            neg_q;
    logic            neg_r;
    logic            by_zero;
    logic            overflow;
    logic            want_mod;
    logic [XLEN-1:0] abs_x;
    logic [XLEN-1:0] abs_y;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] q_fix;
    logic [XLEN-1:0] r_fix;

    assign abs_x = (div_signed && x[XLEN-1]) ? -x : x;
    assign abs_y = (div_signed && y[XLEN-1]) ? -y : y;
    assign trial = {rem, quot[XLEN-1]} - {1'b0, divisor}; // msb set means no fit

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= exec_pkg::DIV_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                exec_pkg::DIV_IDLE:
                begin
                    if (start)
                    begin
                        state <= exec_pkg::DIV_RUN;
                        count <= '0;
                    end
                end
                exec_pkg::DIV_RUN:
                begin
                    count <= count + 1'b1;
                    if (count == CW'(XLEN - 1))
                        state <= exec_pkg::DIV_DONE;
                end
                default: state <= exec_pkg::DIV_IDLE; // DIV_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == exec_pkg::DIV_IDLE && start)
        begin
            quot     <= abs_x;
            rem      <= '0;
            divisor  <= abs_y;
            dividend <= x;
            neg_q    <= div_signed && (x[XLEN-1] ^ y[XLEN-1]);
            neg_r    <= div_signed && x[XLEN-1]; // remainder follows the dividend
            by_zero  <= (y == '0);
            overflow <= div_signed && (x == {1'b1, {(XLEN-1){1'b0}}}) && (y == '1);
            want_mod <= div_mod;
        end
        else if (state == exec_pkg::DIV_RUN)
        begin
            if (!trial[XLEN])
            begin
                rem  <= trial[XLEN-1:0];
                quot <= {quot[XLEN-2:0], 1'b1};
            end
            else
            begin
                rem  <= {rem[XLEN-2:0], quot[XLEN-1]};
                quot <= {quot[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix and special cases, valid while done is high
    assign q_fix = neg_q ? -quot : quot;
    assign r_fix = neg_r ? -rem : rem;
    assign done  = (state == exec_pkg::DIV_DONE);

    always_comb
    begin
        if (by_zero)
            result = want_mod ? dividend : '1;
        else if (overflow)
            result = want_mod ? '0 : dividend;
        else
            result = want_mod ? r_fix : q_fix;
    end

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

    localparam int REG_ADDR_W = 5; // 32 architectural registers

    // execute operation codes, grouped by unit
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,   // imm << 12
        OP_MUL,   // low half
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_B,
        OP_BL,    // writes link
        OP_JIRL   // rj based target, writes link
    } exec_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

/* source/exec_stage.sv */
module exec_stage #(
    parameter int XLEN = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  exec_pkg::exec_op_e            in_op,
    input  logic [XLEN-1:0]               in_pc,
    input  logic [XLEN-1:0]               in_rj_value,
    input  logic [XLEN-1:0]               in_rk_value,
    input  logic [XLEN-1:0]               in_imm,
    input  logic [exec_pkg::REG_ADDR_W-1:0] in_rj_addr,
    input  logic [exec_pkg::REG_ADDR_W-1:0] in_rk_addr,
    input  logic [exec_pkg::REG_ADDR_W-1:0] in_dest,
    input  logic                          in_src1_is_pc,
    input  logic                          in_src2_is_imm,
    input  logic                          in_gr_we,
    input  logic                          fwd_valid,
    input  logic [exec_pkg::REG_ADDR_W-1:0] fwd_dest,
    input  logic [XLEN-1:0]               fwd_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [XLEN-1:0]               out_pc,
    output logic [XLEN-1:0]               out_result,
    output logic [exec_pkg::REG_ADDR_W-1:0] out_dest,
    output logic                          out_gr_we,
    output logic                          br_taken,
    output logic [XLEN-1:0]               br_target
);

    logic [XLEN-1:0] rj_value, rk_value, src1, src2;
    logic            is_mul, is_div, is_br, is_link;
    logic            in_fire, out_free, pend_load;
    logic            div_start, div_signed, div_mod, div_done;
    logic [XLEN-1:0] div_x, div_y, div_result;
    logic [XLEN-1:0] alu_result, mul_result, link_value, br_target_w, exec_result;
    logic            br_taken_w, exec_gr_we;
    logic            div_pending; // divide accepted, result not yet in the output register
    logic            div_have;    // divide finished while the output register was busy
    logic [XLEN-1:0] pend_pc, pend_result;
    logic [exec_pkg::REG_ADDR_W-1:0] pend_dest;
    logic            pend_gr_we;

    // writeback bypass, r0 never forwards
    assign rj_value = (fwd_valid && fwd_dest != '0 && fwd_dest == in_rj_addr) ? fwd_data
                                                                              : in_rj_value;
    assign rk_value = (fwd_valid && fwd_dest != '0 && fwd_dest == in_rk_addr) ? fwd_data
                                                                              : in_rk_value;
    assign src1 = in_src1_is_pc ? in_pc : rj_value;
    assign src2 = in_src2_is_imm ? in_imm : rk_value;

    always_comb
    begin
        is_mul     = 1'b0;
        is_div     = 1'b0;
        is_br      = 1'b0;
        is_link    = 1'b0;
        div_signed = 1'b0;
        div_mod    = 1'b0;
        case (in_op)
            exec_pkg::OP_MUL, exec_pkg::OP_MULH, exec_pkg::OP_MULHU: is_mul = 1'b1;
            exec_pkg::OP_DIV:  {is_div, div_signed} = 2'b11;
            exec_pkg::OP_DIVU: is_div = 1'b1;
            exec_pkg::OP_MOD:  {is_div, div_signed, div_mod} = 3'b111;
            exec_pkg::OP_MODU: {is_div, div_mod} = 2'b11;
            exec_pkg::OP_BEQ, exec_pkg::OP_BNE, exec_pkg::OP_BLT, exec_pkg::OP_BGE,
            exec_pkg::OP_BLTU, exec_pkg::OP_BGEU, exec_pkg::OP_B: is_br = 1'b1;
            exec_pkg::OP_BL, exec_pkg::OP_JIRL: {is_br, is_link} = 2'b11;
            default: ; // alu group
        endcase
    end

    assign out_free  = !out_valid || out_ready;
    assign in_ready  = !div_pending && out_free;
    assign in_fire   = in_valid && in_ready;
    assign div_start = in_fire && is_div;
    assign div_x     = src1;
    assign div_y     = src2;
    assign pend_load = div_pending && (div_have || div_done) && out_free;

    assign exec_result = is_br ? link_value : (is_mul ? mul_result : alu_result);
    assign exec_gr_we  = is_br ? (in_gr_we && is_link) : in_gr_we;

    alu #(.XLEN(XLEN)) u_alu (
        .op(in_op), .src1(src1), .src2(src2), .result(alu_result)
    );

    multiplier #(.XLEN(XLEN)) u_mul (
        .op(in_op), .src1(src1), .src2(src2), .result(mul_result)
    );

    divider #(.XLEN(XLEN)) u_div (
        .clk(clk), .reset(reset), .start(div_start), .div_signed(div_signed),
        .div_mod(div_mod), .x(div_x), .y(div_y), .done(div_done), .result(div_result)
    );

    branch_resolve #(.XLEN(XLEN)) u_branch (
        .op(in_op), .pc(in_pc), .rj(rj_value), .rk(rk_value), .imm(in_imm),
        .taken(br_taken_w), .target(br_target_w), .link(link_value)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid   <= 1'b0;
            br_taken    <= 1'b0;
            div_pending <= 1'b0;
            div_have    <= 1'b0;
        end
        else
        begin
            if (in_fire && !is_div)
            begin
                out_valid <= 1'b1;
                br_taken  <= is_br && br_taken_w;
            end
            else if (pend_load)
            begin
                out_valid <= 1'b1;
                br_taken  <= 1'b0;
            end
            else if (out_ready)
            begin
                out_valid <= 1'b0; // drained
                br_taken  <= 1'b0;
            end
            if (div_start)
                div_pending <= 1'b1;
            else if (pend_load)
                div_pending <= 1'b0;
            if (pend_load)
                div_have <= 1'b0;
            else if (div_done)
                div_have <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_fire && !is_div)
        begin
            out_pc     <= in_pc;
            out_dest   <= in_dest;
            out_gr_we  <= exec_gr_we;
            out_result <= exec_result;
            br_target  <= br_target_w;
        end
        else if (pend_load)
        begin
            out_pc     <= pend_pc;
            out_dest   <= pend_dest;
            out_gr_we  <= pend_gr_we;
            out_result <= div_have ? pend_result : div_result;
            br_target  <= '0;
        end
        if (div_start)
        begin
            pend_pc    <= in_pc;
            pend_dest  <= in_dest;
            pend_gr_we <= in_gr_we;
        end
        if (div_done)
            pend_result <= div_result; // result is only valid during done
    end

endmodule

/* source/multiplier.sv */
module multiplier #(
    parameter int XLEN = 32
) (
    input  exec_pkg::exec_op_e op,
    input  logic [XLEN-1:0]    src1,
    input  logic [XLEN-1:0]    src2,
    output logic [XLEN-1:0]    result
);

    logic                     sign_ext;
    logic signed [XLEN:0]     a;
    logic signed [XLEN:0]     b;
    logic signed [2*XLEN+1:0] product;

    // one extra bit lets a single signed multiply cover both cases
    assign sign_ext = (op != exec_pkg::OP_MULHU);
    assign a        = {sign_ext & src1[XLEN-1], src1};
    assign b        = {sign_ext & src2[XLEN-1], src2};
    assign product  = a * b;

    assign result = (op == exec_pkg::OP_MUL) ? product[XLEN-1:0]
                                             : product[2*XLEN-1:XLEN];

endmodule
